// ==== hdl/bpmPkg.sv ====
/*
 * BPM preprocessor shared definitions
 * Widths, LO table, control register layout and per-channel sum word
 */
`default_nettype none

package bpmPkg;

    localparam int NUM_ADC = 4;
    localparam int ADC_WIDTH = 16;
    localparam int LO_WIDTH = 18;
    localparam int PRODUCT_WIDTH = 17;
    localparam int SUM_WIDTH = 18;
    localparam int ACC_WIDTH = 32;
    localparam int MAG_WIDTH = 18;

    localparam int SAMPLES_PER_TURN = 8;
    localparam int PHASE_WIDTH = $clog2(SAMPLES_PER_TURN);
    localparam int LO_FULL = 131071;
    localparam int LO_DIAG = 92682;

    localparam int TBT_TURNS = 1;
    localparam int MT_TURNS = 2;
    localparam int OV_STRETCH_CYCLES = 32;

    // Control register fields
    localparam int SHIFT_WIDTH = 4;
    localparam int TBT_SHIFT_LSB = 0;
    localparam int MT_SHIFT_LSB = 4;
    localparam int USE_RMS_BIT = 8;
    localparam int CSR_WIDTH = USE_RMS_BIT + 1;

    typedef logic signed [PRODUCT_WIDTH-1:0] product_t;
    typedef logic [MAG_WIDTH-1:0] mag_t;

    // I/Q pair with Q in the upper half, or one power word in RMS mode
    typedef union packed {
        logic [1:0][SUM_WIDTH-1:0] iq;
        logic [2*SUM_WIDTH-1:0]    power;
    } sumWord_u;

    // Cosine table over one turn
    function automatic logic signed [LO_WIDTH-1:0] loCos(input logic [PHASE_WIDTH-1:0] phase);
        case (phase)
            3'd0:    loCos = LO_WIDTH'(LO_FULL);
            3'd1:    loCos = LO_WIDTH'(LO_DIAG);
            3'd2:    loCos = '0;
            3'd3:    loCos = -LO_WIDTH'(LO_DIAG);
            3'd4:    loCos = -LO_WIDTH'(LO_FULL);
            3'd5:    loCos = -LO_WIDTH'(LO_DIAG);
            3'd6:    loCos = '0;
            default: loCos = LO_WIDTH'(LO_DIAG);
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== hdl/demodFrontEnd.sv ====
/*
 * Demodulating front end
 * Control register, LO phase tracking and registered I/Q or RMS products
 */
`timescale 1ns/1ps
`default_nettype none

module demodFrontEnd import bpmPkg::*; (
    input  wire                   clk,
    input  wire                   arstN,
    input  wire [ADC_WIDTH-1:0]   adc0,
    input  wire [ADC_WIDTH-1:0]   adc1,
    input  wire [ADC_WIDTH-1:0]   adc2,
    input  wire [ADC_WIDTH-1:0]   adc3,
    input  wire                   turnMarker,
    input  wire                   useThisSample,
    input  wire                   csrStrobe,
    input  wire [CSR_WIDTH-1:0]   gpioData,
    output product_t              productI0,
    output product_t              productI1,
    output product_t              productI2,
    output product_t              productI3,
    output product_t              productQ0,
    output product_t              productQ1,
    output product_t              productQ2,
    output product_t              productQ3,
    output logic                  turnStart,
    output logic                  loSynced,
    output logic [SHIFT_WIDTH-1:0] tbtShift,
    output logic [SHIFT_WIDTH-1:0] mtShift,
    output logic                  useRms
);

    logic [CSR_WIDTH-1:0]       ctrlReg;
    logic [PHASE_WIDTH-1:0]     phase;
    logic [PHASE_WIDTH-1:0]     samplePhase;
    logic signed [LO_WIDTH-1:0] loCosVal;
    logic signed [LO_WIDTH-1:0] loSinVal;
    logic [ADC_WIDTH-1:0]       adc [NUM_ADC];
    product_t                   prodI [NUM_ADC];
    product_t                   prodQ [NUM_ADC];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrlReg <= '0;
        end else if (csrStrobe) begin
            ctrlReg <= gpioData;
        end
    end

    assign tbtShift = ctrlReg[TBT_SHIFT_LSB +: SHIFT_WIDTH];
    assign mtShift  = ctrlReg[MT_SHIFT_LSB +: SHIFT_WIDTH];
    assign useRms   = ctrlReg[USE_RMS_BIT];

    ////////////////////////////////////////
    // LO phase

    // A marked sample always sits at phase 0
    assign samplePhase = turnMarker ? '0 : phase;
    assign loCosVal = loCos(samplePhase);
    assign loSinVal = loCos(samplePhase - PHASE_WIDTH'(2));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phase     <= '0;
            turnStart <= 1'b0;
            loSynced  <= 1'b0;
        end else begin
            phase     <= samplePhase + 1'b1;
            turnStart <= turnMarker;
            if (turnMarker) begin
                loSynced <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Mixers

    assign adc[0] = adc0;
    assign adc[1] = adc1;
    assign adc[2] = adc2;
    assign adc[3] = adc3;

    for (genvar ch = 0; ch < NUM_ADC; ch++) begin : gMix
        logic signed [ADC_WIDTH-1:0]          sample;
        logic signed [LO_WIDTH-1:0]           mulCos;
        logic signed [LO_WIDTH-1:0]           mulSin;
        logic signed [ADC_WIDTH+LO_WIDTH-1:0] fullI;
        logic signed [ADC_WIDTH+LO_WIDTH-1:0] fullQ;

        assign sample = (useRms && !useThisSample) ? '0 : adc[ch];
        // RMS squares the sample against itself, doubled
        assign mulCos = useRms ? {adc[ch][ADC_WIDTH-1], adc[ch],
                                  {(LO_WIDTH-ADC_WIDTH-1){1'b0}}} : loCosVal;
        assign mulSin = useRms ? '0 : loSinVal;
        assign fullI = sample * mulCos;
        assign fullQ = sample * mulSin;

        always_ff @(posedge clk) begin
            prodI[ch] <= product_t'(fullI >>> (LO_WIDTH - 1));
            prodQ[ch] <= product_t'(fullQ >>> (LO_WIDTH - 1));
        end
    end

    assign productI0 = prodI[0];
    assign productI1 = prodI[1];
    assign productI2 = prodI[2];
    assign productI3 = prodI[3];
    assign productQ0 = prodQ[0];
    assign productQ1 = prodQ[1];
    assign productQ2 = prodQ[2];
    assign productQ3 = prodQ[3];

endmodule

`default_nettype wire

// ==== hdl/turnAccumulator.sv ====
/*
 * Turn accumulator
 * Sums I/Q products over TURNS_PER_SUM turns, then shifts, saturates and latches
 */
`timescale 1ns/1ps
`default_nettype none

module turnAccumulator import bpmPkg::*; #(
    parameter int TURNS_PER_SUM = 1
) (
    input  wire                    clk,
    input  wire                    arstN,
    input  wire product_t          productI0,
    input  wire product_t          productI1,
    input  wire product_t          productI2,
    input  wire product_t          productI3,
    input  wire product_t          productQ0,
    input  wire product_t          productQ1,
    input  wire product_t          productQ2,
    input  wire product_t          productQ3,
    input  wire                    turnStart,
    input  wire                    loSynced,
    input  wire [SHIFT_WIDTH-1:0]  sumShift,
    output sumWord_u               sums0,
    output sumWord_u               sums1,
    output sumWord_u               sums2,
    output sumWord_u               sums3,
    output logic                   sumsValid,
    output logic                   overflow
);

    localparam int COUNT_WIDTH = $clog2(TURNS_PER_SUM + 1);
    localparam logic signed [ACC_WIDTH-1:0] SUM_MAX = ACC_WIDTH'((1 << (SUM_WIDTH - 1)) - 1);
    localparam logic signed [ACC_WIDTH-1:0] SUM_MIN = -SUM_MAX - 1;

    logic                       started;
    logic [COUNT_WIDTH-1:0]     turnCount;
    logic                       newTurn;
    logic                       latchNow;
    logic [2*NUM_ADC-1:0]       satFlags;
    product_t                   prod [NUM_ADC][2];
    logic signed [ACC_WIDTH-1:0] acc [NUM_ADC][2];
    logic [SUM_WIDTH-1:0]       sumVal [NUM_ADC][2];
    sumWord_u                   chanSums [NUM_ADC];

    // Index 0 is I, index 1 is Q
    assign prod[0][0] = productI0;
    assign prod[1][0] = productI1;
    assign prod[2][0] = productI2;
    assign prod[3][0] = productI3;
    assign prod[0][1] = productQ0;
    assign prod[1][1] = productQ1;
    assign prod[2][1] = productQ2;
    assign prod[3][1] = productQ3;

    assign newTurn  = loSynced && turnStart;
    assign latchNow = newTurn && started && (turnCount == COUNT_WIDTH'(TURNS_PER_SUM - 1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            started   <= 1'b0;
            turnCount <= '0;
            sumsValid <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            sumsValid <= latchNow;
            overflow  <= latchNow && (|satFlags);
            if (newTurn) begin
                started <= 1'b1;
                // First marker only opens the sum
                if (!started || latchNow) begin
                    turnCount <= '0;
                end else begin
                    turnCount <= turnCount + 1'b1;
                end
            end
        end
    end

    for (genvar ch = 0; ch < NUM_ADC; ch++) begin : gChan
        for (genvar part = 0; part < 2; part++) begin : gPart
            logic signed [ACC_WIDTH-1:0] shifted;

            assign shifted = acc[ch][part] >>> sumShift;
            assign satFlags[2*ch+part] = (shifted > SUM_MAX) || (shifted < SUM_MIN);

            always_ff @(posedge clk) begin
                if (newTurn) begin
                    acc[ch][part] <= prod[ch][part];
                end else if (loSynced && started) begin
                    acc[ch][part] <= acc[ch][part] + prod[ch][part];
                end
                if (latchNow) begin
                    if (shifted > SUM_MAX) begin
                        sumVal[ch][part] <= SUM_MAX[SUM_WIDTH-1:0];
                    end else if (shifted < SUM_MIN) begin
                        sumVal[ch][part] <= SUM_MIN[SUM_WIDTH-1:0];
                    end else begin
                        sumVal[ch][part] <= shifted[SUM_WIDTH-1:0];
                    end
                end
            end
        end

        assign chanSums[ch].iq = {sumVal[ch][1], sumVal[ch][0]};
    end

    assign sums0 = chanSums[0];
    assign sums1 = chanSums[1];
    assign sums2 = chanSums[2];
    assign sums3 = chanSums[3];

endmodule

`default_nettype wire

// ==== hdl/magnitudeArbiter.sv ====
/*
 * Magnitude arbiter
 * Shares one magnitude estimator between turn-by-turn and multi-turn sums
 */
`timescale 1ns/1ps
`default_nettype none

module magnitudeArbiter import bpmPkg::*; (
    input  wire           clk,
    input  wire           arstN,
    input  wire sumWord_u tbtSums0,
    input  wire sumWord_u tbtSums1,
    input  wire sumWord_u tbtSums2,
    input  wire sumWord_u tbtSums3,
    input  wire           tbtSumsValid,
    input  wire           tbtOverflow,
    input  wire sumWord_u mtSums0,
    input  wire sumWord_u mtSums1,
    input  wire sumWord_u mtSums2,
    input  wire sumWord_u mtSums3,
    input  wire           mtSumsValid,
    input  wire           mtOverflow,
    input  wire           useRms,
    output mag_t          tbtMag0,
    output mag_t          tbtMag1,
    output mag_t          tbtMag2,
    output mag_t          tbtMag3,
    output logic          tbtMagValid,
    output mag_t          mtMag0,
    output mag_t          mtMag1,
    output mag_t          mtMag2,
    output mag_t          mtMag3,
    output logic          mtMagValid,
    output logic          overflowFlag
);

    localparam int CHAN_WIDTH = $clog2(NUM_ADC);
    localparam logic [CHAN_WIDTH-1:0] LAST_CHAN = CHAN_WIDTH'(NUM_ADC - 1);
    localparam int OV_TIMER_WIDTH = $clog2(OV_STRETCH_CYCLES);
    localparam logic [SUM_WIDTH:0] MAG_LIMIT = (SUM_WIDTH + 1)'(2 ** MAG_WIDTH - 1);

    sumWord_u                  tbtIn [NUM_ADC];
    sumWord_u                  mtIn [NUM_ADC];
    sumWord_u                  tbtBuf [NUM_ADC];
    sumWord_u                  mtBuf [NUM_ADC];
    sumWord_u                  work [NUM_ADC];
    sumWord_u                  cur;
    logic                      tbtPending;
    logic                      mtPending;
    logic                      startTbt;
    logic                      startMt;
    logic                      busy;
    logic                      serveMt;
    logic [CHAN_WIDTH-1:0]     chan;
    logic [SUM_WIDTH-1:0]      absI;
    logic [SUM_WIDTH-1:0]      absQ;
    logic [SUM_WIDTH-1:0]      larger;
    logic [SUM_WIDTH-1:0]      smaller;
    logic [SUM_WIDTH:0]        estimate;
    logic                      magSat;
    mag_t                      magOut;
    logic                      magOverflow;
    mag_t                      tbtMag [NUM_ADC];
    mag_t                      mtMag [NUM_ADC];
    logic [OV_TIMER_WIDTH-1:0] ovTimer;

    assign tbtIn = '{tbtSums0, tbtSums1, tbtSums2, tbtSums3};
    assign mtIn  = '{mtSums0, mtSums1, mtSums2, mtSums3};

    ////////////////////////////////////////
    // Pending sets and service order

    // Turn-by-turn always wins when both wait
    assign startTbt = !busy && tbtPending;
    assign startMt  = !busy && !tbtPending && mtPending;

    always_ff @(posedge clk) begin
        if (tbtSumsValid) begin
            tbtBuf <= tbtIn;
        end
        if (mtSumsValid) begin
            mtBuf <= mtIn;
        end
        if (startTbt) begin
            work <= tbtBuf;
        end else if (startMt) begin
            work <= mtBuf;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tbtPending  <= 1'b0;
            mtPending   <= 1'b0;
            busy        <= 1'b0;
            serveMt     <= 1'b0;
            chan        <= '0;
            tbtMagValid <= 1'b0;
            mtMagValid  <= 1'b0;
        end else begin
            tbtPending  <= tbtSumsValid || (tbtPending && !startTbt);
            mtPending   <= mtSumsValid || (mtPending && !startMt);
            tbtMagValid <= busy && !serveMt && (chan == LAST_CHAN);
            mtMagValid  <= busy && serveMt && (chan == LAST_CHAN);
            if (startTbt || startMt) begin
                busy    <= 1'b1;
                serveMt <= startMt;
                chan    <= '0;
            end else if (busy) begin
                chan <= chan + 1'b1;
                if (chan == LAST_CHAN) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Estimator, max plus half of min

    assign cur  = work[chan];
    assign absI = cur.iq[0][SUM_WIDTH-1] ? -cur.iq[0] : cur.iq[0];
    assign absQ = cur.iq[1][SUM_WIDTH-1] ? -cur.iq[1] : cur.iq[1];
    assign larger   = (absI > absQ) ? absI : absQ;
    assign smaller  = (absI > absQ) ? absQ : absI;
    assign estimate = {1'b0, larger} + (SUM_WIDTH + 1)'(smaller >> 1);

    always_comb begin
        if (useRms) begin
            magSat = |cur.power[2*SUM_WIDTH-1:MAG_WIDTH];
            magOut = magSat ? '1 : cur.power[MAG_WIDTH-1:0];
        end else begin
            magSat = estimate > MAG_LIMIT;
            magOut = magSat ? '1 : estimate[MAG_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            if (serveMt) begin
                mtMag[chan] <= magOut;
            end else begin
                tbtMag[chan] <= magOut;
            end
        end
    end

    assign tbtMag0 = tbtMag[0];
    assign tbtMag1 = tbtMag[1];
    assign tbtMag2 = tbtMag[2];
    assign tbtMag3 = tbtMag[3];
    assign mtMag0  = mtMag[0];
    assign mtMag1  = mtMag[1];
    assign mtMag2  = mtMag[2];
    assign mtMag3  = mtMag[3];

    ////////////////////////////////////////
    // Overflow stretch

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            magOverflow  <= 1'b0;
            ovTimer      <= '0;
            overflowFlag <= 1'b0;
        end else begin
            magOverflow <= busy && magSat;
            if (tbtOverflow || mtOverflow || magOverflow) begin
                ovTimer      <= OV_TIMER_WIDTH'(OV_STRETCH_CYCLES - 1);
                overflowFlag <= 1'b1;
            end else if (ovTimer != 0) begin
                ovTimer <= ovTimer - 1'b1;
            end else begin
                overflowFlag <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bpmPreProcess.sv ====
/*
 * BPM preliminary processor
 * Demodulates four ADC channels into turn-by-turn and multi-turn magnitudes
 */
`timescale 1ns/1ps
`default_nettype none

module bpmPreProcess import bpmPkg::*; (
    input  wire                 clk,
    input  wire                 arstN,
    input  wire [ADC_WIDTH-1:0] adc0,
    input  wire [ADC_WIDTH-1:0] adc1,
    input  wire [ADC_WIDTH-1:0] adc2,
    input  wire [ADC_WIDTH-1:0] adc3,
    input  wire                 turnMarker,
    input  wire                 useThisSample,
    input  wire                 csrStrobe,
    input  wire [CSR_WIDTH-1:0] gpioData,
    output logic                loSynced,
    output mag_t                tbtMag0,
    output mag_t                tbtMag1,
    output mag_t                tbtMag2,
    output mag_t                tbtMag3,
    output logic                tbtMagValid,
    output mag_t                mtMag0,
    output mag_t                mtMag1,
    output mag_t                mtMag2,
    output mag_t                mtMag3,
    output logic                mtMagValid,
    output logic                overflowFlag
);

    wire product_t         productI0, productI1, productI2, productI3;
    wire product_t         productQ0, productQ1, productQ2, productQ3;
    wire                   turnStart;
    wire                   useRms;
    wire [SHIFT_WIDTH-1:0] tbtShift;
    wire [SHIFT_WIDTH-1:0] mtShift;
    wire sumWord_u         tbtSums0, tbtSums1, tbtSums2, tbtSums3;
    wire sumWord_u         mtSums0, mtSums1, mtSums2, mtSums3;
    wire                   tbtSumsValid, tbtOverflow;
    wire                   mtSumsValid, mtOverflow;

    demodFrontEnd frontEnd (
        .clk, .arstN, .adc0, .adc1, .adc2, .adc3,
        .turnMarker, .useThisSample, .csrStrobe, .gpioData,
        .productI0, .productI1, .productI2, .productI3,
        .productQ0, .productQ1, .productQ2, .productQ3,
        .turnStart, .loSynced, .tbtShift, .mtShift, .useRms
    );

    // Turn-by-turn and multi-turn sums run side by side
    turnAccumulator #(.TURNS_PER_SUM(TBT_TURNS)) tbtAccumulator (
        .clk, .arstN,
        .productI0, .productI1, .productI2, .productI3,
        .productQ0, .productQ1, .productQ2, .productQ3,
        .turnStart, .loSynced, .sumShift(tbtShift),
        .sums0(tbtSums0), .sums1(tbtSums1), .sums2(tbtSums2), .sums3(tbtSums3),
        .sumsValid(tbtSumsValid), .overflow(tbtOverflow)
    );

    turnAccumulator #(.TURNS_PER_SUM(MT_TURNS)) mtAccumulator (
        .clk, .arstN,
        .productI0, .productI1, .productI2, .productI3,
        .productQ0, .productQ1, .productQ2, .productQ3,
        .turnStart, .loSynced, .sumShift(mtShift),
        .sums0(mtSums0), .sums1(mtSums1), .sums2(mtSums2), .sums3(mtSums3),
        .sumsValid(mtSumsValid), .overflow(mtOverflow)
    );

    magnitudeArbiter arbiter (
        .clk, .arstN,
        .tbtSums0, .tbtSums1, .tbtSums2, .tbtSums3, .tbtSumsValid, .tbtOverflow,
        .mtSums0, .mtSums1, .mtSums2, .mtSums3, .mtSumsValid, .mtOverflow,
        .useRms,
        .tbtMag0, .tbtMag1, .tbtMag2, .tbtMag3, .tbtMagValid,
        .mtMag0, .mtMag1, .mtMag2, .mtMag3, .mtMagValid,
        .overflowFlag
    );

endmodule

`default_nettype wire

// ==== tests/bpmPreProcess_checker.sv ====
/*
 * Control output checks bound into the BPM preprocessor top level
 */
`timescale 1ns/1ps
`default_nettype none

module bpmPreProcess_checker (
    input wire clk,
    input wire arstN,
    input wire tbtMagValid,
    input wire mtMagValid,
    input wire overflowFlag,
    input wire loSynced
);

    int failCount = 0;

    // Everything quiet on the first edge out of reset
    quietAfterReset: assert property (@(posedge clk)
        $rose(arstN) |-> !(tbtMagValid || mtMagValid || overflowFlag || loSynced))
        else begin
            failCount++;
            $error("Control outputs high right after reset");
        end

    oneValidAtATime: assert property (@(posedge clk) disable iff (!arstN)
        !(tbtMagValid && mtMagValid))
        else begin
            failCount++;
            $error("Both magnitude valid pulses high together");
        end

    syncHolds: assert property (@(posedge clk) disable iff (!arstN)
        !$fell(loSynced))
        else begin
            failCount++;
            $error("loSynced fell without reset");
        end

endmodule

bind bpmPreProcess bpmPreProcess_checker assertChecks (
    .clk, .arstN, .tbtMagValid, .mtMagValid, .overflowFlag, .loSynced
);

`default_nettype wire

// ==== tests/bpmPreProcessTb.sv ====
/*
 * BPM preprocessor testbench
 * Trace-driven stimulus with per-set comparison of both magnitude streams
 */
`timescale 1ns/1ps
`default_nettype none

module bpmPreProcessTb import bpmPkg::*; ;

    localparam string TRACE_FILE = "tests/bpmPreProcess_trace.txt";
    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;

    typedef logic [NUM_ADC-1:0][MAG_WIDTH-1:0] magSet_t;

    // One trace record, a register write or a sample repeated count times
    typedef struct packed {
        logic isWrite;
        logic marker;
        logic useSample;
        int   csr;
        int   adcVal0;
        int   adcVal1;
        int   adcVal2;
        int   adcVal3;
        int   count;
    } stim_t;

    logic                 clk;
    logic                 arstN;
    logic [ADC_WIDTH-1:0] adc0, adc1, adc2, adc3;
    logic                 turnMarker;
    logic                 useThisSample;
    logic                 csrStrobe;
    logic [CSR_WIDTH-1:0] gpioData;
    wire                  loSynced;
    wire mag_t            tbtMag0, tbtMag1, tbtMag2, tbtMag3;
    wire mag_t            mtMag0, mtMag1, mtMag2, mtMag3;
    wire                  tbtMagValid;
    wire                  mtMagValid;
    wire                  overflowFlag;

    stim_t   stimQ [$];
    magSet_t expTbt [$];
    magSet_t expMt [$];
    int      sampleCount = 0;
    int      errorCount = 0;
    int      testCount = 0;
    int      failedTests = 0;
    int      tbtSeen = 0;
    int      mtSeen = 0;
    int      syncErrors = 0;
    bit      traceLoaded = 0;
    bit      ovRose = 0;
    bit      ovFell = 0;
    bit      syncExpected = 0;

    bpmPreProcess DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Trace loading

    task automatic loadTrace();
        int      fd;
        int      n;
        int      f [7];
        string   line;
        stim_t   rec;
        magSet_t set;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open trace file %s", TRACE_FILE);
            errorCount++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            rec = '0;
            case (line[0])
                "W": begin
                    n = $sscanf(line, "W %h", f[0]);
                    rec.isWrite = 1'b1;
                    rec.csr = f[0];
                    rec.count = 1;
                end
                "S": begin
                    n = $sscanf(line, "S %d %d %d %d %d %d %d",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                    n = n - 6;
                    rec.marker = f[0] != 0;
                    rec.useSample = f[1] != 0;
                    rec.adcVal0 = f[2];
                    rec.adcVal1 = f[3];
                    rec.adcVal2 = f[4];
                    rec.adcVal3 = f[5];
                    rec.count = f[6];
                end
                default: begin
                    n = $sscanf(line, "%*c %d %d %d %d", f[0], f[1], f[2], f[3]) - 3;
                    for (int ch = 0; ch < NUM_ADC; ch++) begin
                        set[ch] = MAG_WIDTH'(f[ch]);
                    end
                end
            endcase
            if (n != 1 || !(line[0] inside {"W", "S", "T", "M"})) begin
                $display("Malformed trace line: %s", line);
                errorCount++;
            end else if (line[0] == "T") begin
                expTbt.push_back(set);
            end else if (line[0] == "M") begin
                expMt.push_back(set);
            end else begin
                stimQ.push_back(rec);
                sampleCount += rec.count;
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////
    // Stimulus

    task automatic applyRecord(input stim_t rec);
        for (int k = 0; k < rec.count; k++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            csrStrobe     = rec.isWrite;
            gpioData      = rec.isWrite ? CSR_WIDTH'(rec.csr) : '0;
            turnMarker    = rec.marker && (k == 0);
            useThisSample = rec.useSample;
            adc0          = ADC_WIDTH'(rec.adcVal0);
            adc1          = ADC_WIDTH'(rec.adcVal1);
            adc2          = ADC_WIDTH'(rec.adcVal2);
            adc3          = ADC_WIDTH'(rec.adcVal3);
        end
    endtask

    task automatic compareSet(input logic isMt, input magSet_t got);
        magSet_t want;
        int      mismatches;
        int      setIndex;
        string   stream;
        stream = isMt ? "multi-turn" : "turn-by-turn";
        setIndex = isMt ? mtSeen : tbtSeen;
        mismatches = 0;
        testCount++;
        if ((isMt && expMt.size() == 0) || (!isMt && expTbt.size() == 0)) begin
            $display("Got a %s magnitude set with no expected set left", stream);
            errorCount++;
            failedTests++;
            return;
        end
        if (isMt) begin
            want = expMt.pop_front();
            mtSeen++;
        end else begin
            want = expTbt.pop_front();
            tbtSeen++;
        end
        for (int ch = 0; ch < NUM_ADC; ch++) begin
            assert (got[ch] == want[ch]) else begin
                $display("[ERROR] %0t ns: %s set %0d channel %0d is %0d, expected %0d",
                         $time, stream, setIndex, ch, got[ch], want[ch]);
                mismatches++;
            end
        end
        errorCount += mismatches;
        if (mismatches != 0) begin
            failedTests++;
        end
        $display("Test %0d, %s set %0d: %s", testCount, stream, setIndex,
                 (mismatches == 0) ? "passed" : "FAILED");
    endtask

    // Sync comes up on the first edge that takes a marker
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            syncExpected <= 1'b0;
        end else if (turnMarker) begin
            syncExpected <= 1'b1;
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (arstN) begin
            assert (loSynced == syncExpected) else begin
                $display("[ERROR] %0t ns: loSynced is %0b, expected %0b",
                         $time, loSynced, syncExpected);
                syncErrors++;
                errorCount++;
            end
            if (tbtMagValid) begin
                compareSet(1'b0, {tbtMag3, tbtMag2, tbtMag1, tbtMag0});
            end
            if (mtMagValid) begin
                compareSet(1'b1, {mtMag3, mtMag2, mtMag1, mtMag0});
            end
            if (overflowFlag && !ovRose) begin
                ovRose = 1'b1;
            end else if (ovRose && !overflowFlag && !ovFell) begin
                ovFell = 1'b1;
            end
        end
    end

    initial begin
        arstN         = 1'b0;
        adc0          = '0;
        adc1          = '0;
        adc2          = '0;
        adc3          = '0;
        turnMarker    = 1'b0;
        useThisSample = 1'b0;
        csrStrobe     = 1'b0;
        gpioData      = '0;
        loadTrace();
        traceLoaded = 1'b1;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY arstN = 1'b1;
        foreach (stimQ[i]) begin
            applyRecord(stimQ[i]);
        end
        applyRecord('{isWrite: 1'b0, marker: 1'b0, useSample: 1'b0, csr: 0,
                      adcVal0: 0, adcVal1: 0, adcVal2: 0, adcVal3: 0, count: 1});
        // Drain both streams, then let the overflow stretch run out
        while (expTbt.size() != 0 || expMt.size() != 0) begin
            @(posedge clk);
        end
        for (int c = 0; c < 4 * OV_STRETCH_CYCLES && !ovFell; c++) begin
            @(posedge clk);
        end
        testCount++;
        assert (ovRose && ovFell) else begin
            $display("Overflow flag did not rise and fall again");
            errorCount++;
            failedTests++;
        end
        $display("Test %0d, overflow flag stretch: %s", testCount,
                 (ovRose && ovFell) ? "passed" : "FAILED");
        testCount++;
        if (syncErrors != 0) begin
            failedTests++;
        end
        $display("Test %0d, loSynced tracking: %s", testCount,
                 (syncErrors == 0) ? "passed" : "FAILED");
        errorCount += DUT.assertChecks.failCount;
        $display("Tests: %0d, failed: %0d, errors: %0d, sets: %0d tbt %0d mt",
                 testCount, failedTests, errorCount, tbtSeen, mtSeen);
        if (errorCount == 0 && failedTests == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the trace length
    initial begin
        wait (traceLoaded);
        #(longint'(CLK_PERIOD) * (sampleCount + 200));
        $display("Timeout: the DUT did not deliver every expected set in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/bpmPreProcess_trace.txt ====
# W csr(hex): tbt shift [3:0], mt shift [7:4], rms [8]
# S marker useThisSample adc0 adc1 adc2 adc3 repeat (marker on first copy only)
# T/M mag0 mag1 mag2 mag3: expected turn-by-turn / multi-turn set
W 010
S 1 1 0 0 0 0 8
S 1 1 4096 -4096 0 4096 1
S 0 1 1024 -1024 0 0 1
S 0 1 0 0 2048 0 1
S 0 1 -1024 1024 0 0 1
S 0 1 -4096 4096 0 -4096 1
S 0 1 -1024 1024 0 0 1
S 0 1 0 0 -2048 0 1
S 0 1 1024 -1024 0 0 1
S 1 1 0 0 0 0 16
T 0 0 0 0
T 11087 11093 4094 8190
M 5543 5546 2047 4095
W 021
S 1 1 4096 -4096 0 4096 1
S 0 1 1024 -1024 0 0 1
S 0 1 0 0 2048 0 1
S 0 1 -1024 1024 0 0 1
S 0 1 -4096 4096 0 -4096 1
S 0 1 -1024 1024 0 0 1
S 0 1 0 0 -2048 0 1
S 0 1 1024 -1024 0 0 1
S 1 1 0 0 0 0 16
T 0 0 0 0
T 5543 5546 2047 4095
M 2771 2773 1023 2047
# Turn cut short after five samples, then a full turn from phase 0
S 1 1 4096 -4096 0 4096 1
S 0 1 1024 -1024 0 0 1
S 0 1 0 0 2048 0 1
S 0 1 -1024 1024 0 0 1
S 0 1 -4096 4096 0 -4096 1
S 1 1 4096 -4096 0 4096 1
S 0 1 1024 -1024 0 0 1
S 0 1 0 0 2048 0 1
S 0 1 -1024 1024 0 0 1
S 0 1 -4096 4096 0 -4096 1
S 0 1 -1024 1024 0 0 1
S 0 1 0 0 -2048 0 1
S 0 1 1024 -1024 0 0 1
S 1 1 0 0 0 0 16
T 0 0 0 0
T 4819 4821 1023 4095
M 2409 2411 511 2047
T 5543 5546 2047 4095
W 100
S 1 1 1024 -2048 4096 300 4
S 0 0 8000 8000 8000 8000 4
S 1 1 0 0 0 0 16
T 0 0 0 0
M 0 0 0 0
T 64 256 1024 4
S 1 1 -32768 16384 0 0 8
S 1 1 0 0 0 0 16
S 1 1 0 0 0 0 16
T 0 0 0 0
M 0 0 0 0
T 131071 32768 0 0
T 0 0 0 0
M 0 0 0 0

// ==== bpmPreProcess.f ====
hdl/bpmPkg.sv
hdl/demodFrontEnd.sv
hdl/turnAccumulator.sv
hdl/magnitudeArbiter.sv
hdl/bpmPreProcess.sv
tests/bpmPreProcess_checker.sv
tests/bpmPreProcessTb.sv

// ==== Makefile ====
# Verilator build and run for the BPM preprocessor testbench
TOP := bpmPreProcessTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f bpmPreProcess.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

lint:
	verilator --lint-only --timing --assert -f bpmPreProcess.f --top-module $(TOP)

clean:
	rm -rf obj_dir
